// File: verilog/rv_decode_pkg.sv
// RISC-V decode definitions
package rv_decode_pkg;

  localparam int XLEN     = 64;
  localparam int INST_W   = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  // major opcodes
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and arithmetic shifts

  typedef enum logic [5:0] {
    ID_LUI, ID_AUIPC, ID_JAL, ID_JALR,
    ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU,
    ID_LB, ID_LH, ID_LW, ID_LBU, ID_LHU, ID_LWU, ID_LD,
    ID_SB, ID_SH, ID_SW, ID_SD,
    ID_ADDI, ID_SLTI, ID_SLTIU, ID_XORI, ID_ORI, ID_ANDI,
    ID_SLLI, ID_SRLI, ID_SRAI,
    ID_ADDIW, ID_SLLIW, ID_SRLIW, ID_SRAIW,
    ID_ADD, ID_SUB, ID_SLL, ID_SLT, ID_SLTU,
    ID_XOR, ID_SRL, ID_SRA, ID_OR, ID_AND,
    ID_ADDW, ID_SUBW, ID_SLLW, ID_SRLW, ID_SRAW,
    ID_INVALID
  } inst_id_t;

  typedef enum logic [2:0] {
    FMT_R, FMT_I, FMT_U, FMT_S, FMT_B, FMT_J, FMT_NONE
  } inst_fmt_t;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'b00000,
    ALU_SUB      = 5'b00001,
    ALU_SLT      = 5'b00010,
    ALU_SLTU     = 5'b00011,
    ALU_XOR      = 5'b00100,
    ALU_AND      = 5'b00101,
    ALU_OR       = 5'b00110,
    ALU_SLL      = 5'b00111,
    ALU_SRL      = 5'b01000,
    ALU_SRA      = 5'b01001,
    ALU_COPY_IMM = 5'b01111,
    ALU_INVALID  = 5'b11111
  } alu_ctr_t;

  // unsigned branches share LT/GE codes
  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_EQ   = 3'b100,
    BR_NE   = 3'b101,
    BR_LT   = 3'b110,
    BR_GE   = 3'b111
  } branch_t;

  typedef enum logic [2:0] {
    MEM_B    = 3'b000,
    MEM_BU   = 3'b001,
    MEM_H    = 3'b010,
    MEM_HU   = 3'b011,
    MEM_W    = 3'b100,
    MEM_WU   = 3'b101,
    MEM_D    = 3'b110,
    MEM_NONE = 3'b111
  } mem_op_t;

  typedef enum logic [1:0] {
    B_RS2  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10  // return address pc+4
  } alu_b_src_t;

  typedef struct packed {
    logic       alu_a_pc;
    alu_b_src_t alu_b_src;
    alu_ctr_t   alu_ctr;
    branch_t    branch;
    logic       mem_re;
    logic       mem_wr;
    logic       mem_to_reg;
    mem_op_t    mem_op;
    logic       word_cut;
    logic       reg_wr;
    logic       invalid;
  } ctrl_t;

endpackage

// File: verilog/inst_classify.sv
// Instruction classifier
`timescale 1ns/100ps

module inst_classify (
  input  logic [rv_decode_pkg::INST_W-1:0] i_inst,
  output rv_decode_pkg::inst_id_t          o_id
);

  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    o_id = ID_INVALID;
    case (opcode)
      OPC_LUI:   o_id = ID_LUI;
      OPC_AUIPC: o_id = ID_AUIPC;
      OPC_JAL:   o_id = ID_JAL;
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_id = ID_JALR;
        end
      end
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  o_id = ID_BEQ;
          3'b001:  o_id = ID_BNE;
          3'b100:  o_id = ID_BLT;
          3'b101:  o_id = ID_BGE;
          3'b110:  o_id = ID_BLTU;
          3'b111:  o_id = ID_BGEU;
          default: o_id = ID_INVALID;
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  o_id = ID_LB;
          3'b001:  o_id = ID_LH;
          3'b010:  o_id = ID_LW;
          3'b011:  o_id = ID_LD;
          3'b100:  o_id = ID_LBU;
          3'b101:  o_id = ID_LHU;
          3'b110:  o_id = ID_LWU;
          default: o_id = ID_INVALID;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  o_id = ID_SB;
          3'b001:  o_id = ID_SH;
          3'b010:  o_id = ID_SW;
          3'b011:  o_id = ID_SD;
          default: o_id = ID_INVALID;
        endcase
      end
      OPC_OP_IMM: begin
        // 64-bit shamt takes bit 25, so only 31:26 is funct
        case ({funct7[6:1], funct3})
          {F7_BASE[6:1], 3'b001}: o_id = ID_SLLI;
          {F7_BASE[6:1], 3'b101}: o_id = ID_SRLI;
          {F7_ALT[6:1], 3'b101}:  o_id = ID_SRAI;
          default: begin
            case (funct3)
              3'b000:  o_id = ID_ADDI;
              3'b010:  o_id = ID_SLTI;
              3'b011:  o_id = ID_SLTIU;
              3'b100:  o_id = ID_XORI;
              3'b110:  o_id = ID_ORI;
              3'b111:  o_id = ID_ANDI;
              default: o_id = ID_INVALID; // bad shift funct
            endcase
          end
        endcase
      end
      OPC_OP_IMM_32: begin
        case ({funct7, funct3})
          {F7_BASE, 3'b001}: o_id = ID_SLLIW;
          {F7_BASE, 3'b101}: o_id = ID_SRLIW;
          {F7_ALT, 3'b101}:  o_id = ID_SRAIW;
          default: o_id = (funct3 == 3'b000) ? ID_ADDIW : ID_INVALID;
        endcase
      end
      OPC_OP: begin
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: o_id = ID_ADD;
          {F7_ALT, 3'b000}:  o_id = ID_SUB;
          {F7_BASE, 3'b001}: o_id = ID_SLL;
          {F7_BASE, 3'b010}: o_id = ID_SLT;
          {F7_BASE, 3'b011}: o_id = ID_SLTU;
          {F7_BASE, 3'b100}: o_id = ID_XOR;
          {F7_BASE, 3'b101}: o_id = ID_SRL;
          {F7_ALT, 3'b101}:  o_id = ID_SRA;
          {F7_BASE, 3'b110}: o_id = ID_OR;
          {F7_BASE, 3'b111}: o_id = ID_AND;
          default:           o_id = ID_INVALID; // M ext lands here
        endcase
      end
      OPC_OP_32: begin
        case ({funct7, funct3})
          {F7_BASE, 3'b000}: o_id = ID_ADDW;
          {F7_ALT, 3'b000}:  o_id = ID_SUBW;
          {F7_BASE, 3'b001}: o_id = ID_SLLW;
          {F7_BASE, 3'b101}: o_id = ID_SRLW;
          {F7_ALT, 3'b101}:  o_id = ID_SRAW;
          default:           o_id = ID_INVALID;
        endcase
      end
      default: o_id = ID_INVALID; // system, csr, fence, unknown
    endcase
  end

endmodule

// File: verilog/imm_gen.sv
// Immediate generator
`timescale 1ns/100ps

module imm_gen (
  input  logic [rv_decode_pkg::INST_W-1:0] i_inst,
  input  rv_decode_pkg::inst_fmt_t         i_fmt,
  output logic [rv_decode_pkg::XLEN-1:0]   o_imm
);

  import rv_decode_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  always_comb begin
    case (i_fmt)
      FMT_I:   o_imm = imm_i;
      FMT_U:   o_imm = imm_u;
      FMT_S:   o_imm = imm_s;
      FMT_B:   o_imm = imm_b;
      FMT_J:   o_imm = imm_j;
      default: o_imm = '0; // R and none carry no immediate
    endcase
  end

endmodule

// File: verilog/ctrl_gen.sv
// Execute control generator
`timescale 1ns/100ps

module ctrl_gen (
  input  rv_decode_pkg::inst_id_t          i_id,
  input  logic [rv_decode_pkg::INST_W-1:0] i_inst,
  output rv_decode_pkg::inst_fmt_t         o_fmt,
  output rv_decode_pkg::ctrl_t             o_ctrl
);

  import rv_decode_pkg::*;

  alu_ctr_t alu_ctr;
  branch_t  branch;
  mem_op_t  mem_op;

  always_comb begin
    case (i_id)
      ID_ADD, ID_SUB, ID_SLL, ID_SLT, ID_SLTU, ID_XOR, ID_SRL, ID_SRA, ID_OR, ID_AND,
      ID_ADDW, ID_SUBW, ID_SLLW, ID_SRLW, ID_SRAW: o_fmt = FMT_R;
      ID_JALR, ID_LB, ID_LH, ID_LW, ID_LBU, ID_LHU, ID_LWU, ID_LD,
      ID_ADDI, ID_SLTI, ID_SLTIU, ID_XORI, ID_ORI, ID_ANDI, ID_SLLI, ID_SRLI, ID_SRAI,
      ID_ADDIW, ID_SLLIW, ID_SRLIW, ID_SRAIW: o_fmt = FMT_I;
      ID_LUI, ID_AUIPC:                       o_fmt = FMT_U;
      ID_SB, ID_SH, ID_SW, ID_SD:             o_fmt = FMT_S;
      ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_BLTU, ID_BGEU: o_fmt = FMT_B;
      ID_JAL:                                 o_fmt = FMT_J;
      default:                                o_fmt = FMT_NONE;
    endcase
  end

  always_comb begin
    case (i_id)
      ID_LUI: alu_ctr = ALU_COPY_IMM;
      ID_AUIPC, ID_JAL, ID_JALR, ID_LB, ID_LH, ID_LW, ID_LBU, ID_LHU, ID_LWU, ID_LD,
      ID_SB, ID_SH, ID_SW, ID_SD, ID_ADDI, ID_ADDIW, ID_ADD, ID_ADDW: alu_ctr = ALU_ADD;
      ID_SUB, ID_SUBW:                                 alu_ctr = ALU_SUB;
      ID_BEQ, ID_BNE, ID_BLT, ID_BGE, ID_SLTI, ID_SLT: alu_ctr = ALU_SLT;
      ID_BLTU, ID_BGEU, ID_SLTIU, ID_SLTU:             alu_ctr = ALU_SLTU;
      ID_XORI, ID_XOR:                                 alu_ctr = ALU_XOR;
      ID_ANDI, ID_AND:                                 alu_ctr = ALU_AND;
      ID_ORI, ID_OR:                                   alu_ctr = ALU_OR;
      ID_SLLI, ID_SLLIW, ID_SLL, ID_SLLW:              alu_ctr = ALU_SLL;
      ID_SRLI, ID_SRLIW, ID_SRL, ID_SRLW:              alu_ctr = ALU_SRL;
      ID_SRAI, ID_SRAIW, ID_SRA, ID_SRAW:              alu_ctr = ALU_SRA;
      default:                                         alu_ctr = ALU_INVALID;
    endcase
  end

  always_comb begin
    case (i_id)
      ID_JAL:           branch = BR_JAL;
      ID_JALR:          branch = BR_JALR;
      ID_BEQ:           branch = BR_EQ;
      ID_BNE:           branch = BR_NE;
      ID_BLT, ID_BLTU:  branch = BR_LT; // signedness from alu_ctr
      ID_BGE, ID_BGEU:  branch = BR_GE;
      default:          branch = BR_NONE;
    endcase
  end

  always_comb begin
    case (i_id)
      ID_LB, ID_SB: mem_op = MEM_B;
      ID_LBU:       mem_op = MEM_BU;
      ID_LH, ID_SH: mem_op = MEM_H;
      ID_LHU:       mem_op = MEM_HU;
      ID_LW, ID_SW: mem_op = MEM_W;
      ID_LWU:       mem_op = MEM_WU;
      ID_LD, ID_SD: mem_op = MEM_D;
      default:      mem_op = MEM_NONE;
    endcase
  end

  always_comb begin
    o_ctrl.alu_a_pc   = i_id inside {ID_JAL, ID_JALR, ID_AUIPC};
    if (i_id inside {ID_JAL, ID_JALR}) begin
      o_ctrl.alu_b_src = B_FOUR;
    end else if (o_fmt inside {FMT_I, FMT_U, FMT_S, FMT_B}) begin
      o_ctrl.alu_b_src = B_IMM;
    end else begin
      o_ctrl.alu_b_src = B_RS2;
    end
    o_ctrl.alu_ctr    = alu_ctr;
    o_ctrl.branch     = branch;
    o_ctrl.mem_re     = (o_fmt == FMT_I) && (mem_op != MEM_NONE); // loads only
    o_ctrl.mem_wr     = (o_fmt == FMT_S);
    o_ctrl.mem_to_reg = (o_fmt == FMT_I) && (mem_op != MEM_NONE);
    o_ctrl.mem_op     = mem_op;
    o_ctrl.word_cut   = i_id inside {ID_ADDIW, ID_SLLIW, ID_SRLIW, ID_SRAIW,
                                     ID_ADDW, ID_SUBW, ID_SLLW, ID_SRLW, ID_SRAW};
    o_ctrl.reg_wr     = o_fmt inside {FMT_R, FMT_I, FMT_U, FMT_J};
    // all-zero word is a bubble, not an illegal op
    o_ctrl.invalid    = (i_id == ID_INVALID) && (i_inst != '0);
  end

endmodule

// File: verilog/gpr_file.sv
// General purpose register file
`timescale 1ns/100ps

module gpr_file (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic [rv_decode_pkg::REG_AW-1:0] i_raddr1,
  input  logic [rv_decode_pkg::REG_AW-1:0] i_raddr2,
  input  logic [rv_decode_pkg::REG_AW-1:0] i_waddr,
  input  logic [rv_decode_pkg::XLEN-1:0]   i_wdata,
  input  logic                             i_wen,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rdata1,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rdata2
);

  import rv_decode_pkg::*;

  logic [XLEN-1:0] regs [1:NUM_REGS-1]; // x0 has no storage

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: verilog/idu_top.sv
// Instruction decode stage
`timescale 1ns/100ps

module idu_top (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic [rv_decode_pkg::INST_W-1:0] i_inst,
  input  logic [rv_decode_pkg::XLEN-1:0]   i_wb_data,
  input  logic                             i_wb_valid,
  output rv_decode_pkg::ctrl_t             o_ctrl,
  output logic [rv_decode_pkg::XLEN-1:0]   o_imm,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rs1_data,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rs2_data
);

  import rv_decode_pkg::*;

  inst_id_t  inst_id;
  inst_fmt_t inst_fmt;

  inst_classify u_classify (
    .i_inst (i_inst),
    .o_id   (inst_id)
  );

  ctrl_gen u_ctrl (
    .i_id   (inst_id),
    .i_inst (i_inst),
    .o_fmt  (inst_fmt),
    .o_ctrl (o_ctrl)
  );

  imm_gen u_imm (
    .i_inst (i_inst),
    .i_fmt  (inst_fmt),
    .o_imm  (o_imm)
  );

  gpr_file u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (i_inst[19:15]),  // rs1
    .i_raddr2 (i_inst[24:20]),  // rs2
    .i_waddr  (i_inst[11:7]),   // rd
    .i_wdata  (i_wb_data),
    .i_wen    (i_wb_valid & o_ctrl.reg_wr),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

// File: verification/idu_tb.sv
// Decode stage testbench
`timescale 1ns/100ps

module idu_tb;

  import rv_decode_pkg::*;

  typedef struct packed {
    logic [INST_W-1:0] inst;
    logic [XLEN-1:0]   wb_data;
    logic              wb_valid;
    ctrl_t             ctrl;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
  } vec_t;

  logic              i_clk;
  logic              i_rst_n;
  logic [INST_W-1:0] i_inst;
  logic [XLEN-1:0]   i_wb_data;
  logic              i_wb_valid;
  ctrl_t             o_ctrl;
  logic [XLEN-1:0]   o_imm;
  logic [XLEN-1:0]   o_rs1_data;
  logic [XLEN-1:0]   o_rs2_data;

  vec_t            table_q [$];
  logic [XLEN-1:0] model [NUM_REGS]; // expected register contents
  logic [63:0]     lcg_state;

  idu_top dut0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_inst     (i_inst),
    .i_wb_data  (i_wb_data),
    .i_wb_valid (i_wb_valid),
    .o_ctrl     (o_ctrl),
    .o_imm      (o_imm),
    .o_rs1_data (o_rs1_data),
    .o_rs2_data (o_rs2_data)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  initial begin
    i_rst_n = 1'b0;
    repeat (5) @(posedge i_clk);
    #2 i_rst_n = 1'b1;
  end

  function automatic logic [63:0] next_rand();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    logic [63:0] r;
    r = next_rand();
    return r[63:59]; // upper bits are the better ones
  endfunction

  function automatic logic rand_bit();
    logic [63:0] r;
    r = next_rand();
    return r[63];
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc,
                                        logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(logic [63:0] imm, logic [2:0] f3, logic [6:0] opc,
                                        logic [4:0] rd, logic [4:0] rs1);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [63:0] imm, logic [2:0] f3,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(logic [63:0] imm, logic [2:0] f3,
                                        logic [4:0] rs1, logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(logic [63:0] imm, logic [6:0] opc, logic [4:0] rd);
    return {imm[31:12], rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(logic [63:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  function automatic ctrl_t alu_ctrl(alu_ctr_t alu, alu_b_src_t src, logic wcut);
    ctrl_t c;
    c.alu_a_pc   = 1'b0;
    c.alu_b_src  = src;
    c.alu_ctr    = alu;
    c.branch     = BR_NONE;
    c.mem_re     = 1'b0;
    c.mem_wr     = 1'b0;
    c.mem_to_reg = 1'b0;
    c.mem_op     = MEM_NONE;
    c.word_cut   = wcut;
    c.reg_wr     = 1'b1;
    c.invalid    = 1'b0;
    return c;
  endfunction

  function automatic ctrl_t pc_ctrl(alu_b_src_t src, branch_t br);
    ctrl_t c;
    c          = alu_ctrl(ALU_ADD, src, 1'b0);
    c.alu_a_pc = 1'b1;
    c.branch   = br;
    return c;
  endfunction

  function automatic ctrl_t load_ctrl(mem_op_t mop);
    ctrl_t c;
    c            = alu_ctrl(ALU_ADD, B_IMM, 1'b0);
    c.mem_re     = 1'b1;
    c.mem_to_reg = 1'b1;
    c.mem_op     = mop;
    return c;
  endfunction

  function automatic ctrl_t store_ctrl(mem_op_t mop);
    ctrl_t c;
    c        = alu_ctrl(ALU_ADD, B_IMM, 1'b0);
    c.reg_wr = 1'b0;
    c.mem_wr = 1'b1;
    c.mem_op = mop;
    return c;
  endfunction

  function automatic ctrl_t branch_ctrl(branch_t br, alu_ctr_t alu);
    ctrl_t c;
    c        = alu_ctrl(alu, B_IMM, 1'b0);
    c.reg_wr = 1'b0;
    c.branch = br;
    return c;
  endfunction

  function automatic ctrl_t invalid_ctrl(logic flag);
    ctrl_t c;
    c         = alu_ctrl(ALU_INVALID, B_RS2, 1'b0);
    c.reg_wr  = 1'b0;
    c.invalid = flag;
    return c;
  endfunction

  task automatic push(logic [31:0] inst, logic valid, ctrl_t exp_ctrl, logic [63:0] exp_imm);
    vec_t v;
    v.inst     = inst;
    v.wb_data  = next_rand();
    v.wb_valid = valid;
    v.ctrl     = exp_ctrl;
    v.imm      = exp_imm;
    v.rs1      = model[inst[19:15]];
    v.rs2      = model[inst[24:20]];
    table_q.push_back(v);
    // write lands at the edge that closes this entry
    if (valid && exp_ctrl.reg_wr && (inst[11:7] != 5'd0)) begin
      model[inst[11:7]] = v.wb_data;
    end
  endtask

  task automatic add_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc, alu_ctr_t alu,
                       logic wcut);
    push(enc_r(f7, f3, opc, rand_reg(), rand_reg(), rand_reg()), rand_bit(),
         alu_ctrl(alu, B_RS2, wcut), '0);
  endtask

  task automatic add_i(logic [63:0] imm, logic [2:0] f3, logic [6:0] opc, ctrl_t c);
    push(enc_i(imm, f3, opc, rand_reg(), rand_reg()), rand_bit(), c, imm);
  endtask

  task automatic add_u(logic [63:0] imm, logic [6:0] opc, ctrl_t c);
    push(enc_u(imm, opc, rand_reg()), rand_bit(), c, imm);
  endtask

  task automatic add_j(logic [63:0] imm);
    push(enc_j(imm, rand_reg()), rand_bit(), pc_ctrl(B_FOUR, BR_JAL), imm);
  endtask

  task automatic add_s(logic [63:0] imm, logic [2:0] f3, mem_op_t mop);
    push(enc_s(imm, f3, rand_reg(), rand_reg()), 1'b1, store_ctrl(mop), imm);
  endtask

  task automatic add_b(logic [63:0] imm, logic [2:0] f3, branch_t br, alu_ctr_t alu);
    push(enc_b(imm, f3, rand_reg(), rand_reg()), 1'b1, branch_ctrl(br, alu), imm);
  endtask

  task automatic build_table();
    // all registers zero after reset
    for (int r = 0; r < 16; r++) begin
      push(enc_r(F7_BASE, 3'b000, OPC_OP, 5'd0, r[4:0], 5'(r + 16)), 1'b0,
           alu_ctrl(ALU_ADD, B_RS2, 1'b0), '0);
    end
    push(enc_i(64'hffff_ffff_ffff_fffb, 3'b000, OPC_OP_IMM, 5'd5, 5'd0), 1'b1,
         alu_ctrl(ALU_ADD, B_IMM, 1'b0), 64'hffff_ffff_ffff_fffb);
    push(enc_u(64'h0000_0000_1234_5000, OPC_LUI, 5'd6), 1'b1,
         alu_ctrl(ALU_COPY_IMM, B_IMM, 1'b0), 64'h0000_0000_1234_5000);
    push(enc_r(F7_BASE, 3'b000, OPC_OP, 5'd0, 5'd5, 5'd6), 1'b0,
         alu_ctrl(ALU_ADD, B_RS2, 1'b0), '0);
    push(enc_i(64'h3, 3'b000, OPC_OP_IMM, 5'd8, 5'd0), 1'b1, alu_ctrl(ALU_ADD, B_IMM, 1'b0), 64'h3);
    push(enc_i(64'h7, 3'b000, OPC_OP_IMM, 5'd9, 5'd0), 1'b1, alu_ctrl(ALU_ADD, B_IMM, 1'b0), 64'h7);
    push(enc_i(64'h1, 3'b000, OPC_OP_IMM, 5'd0, 5'd0), 1'b1, alu_ctrl(ALU_ADD, B_IMM, 1'b0), 64'h1);
    push(enc_i(64'h2, 3'b000, OPC_OP_IMM, 5'd8, 5'd0), 1'b0, alu_ctrl(ALU_ADD, B_IMM, 1'b0), 64'h2);
    push(enc_s(64'h28, 3'b010, 5'd1, 5'd2), 1'b1, store_ctrl(MEM_W), 64'h28);     // rd slot is 8
    push(enc_b(64'h808, 3'b000, 5'd3, 5'd4), 1'b1, branch_ctrl(BR_EQ, ALU_SLT), 64'h808); // 9
    push(enc_r(F7_BASE, 3'b000, OPC_OP, 5'd0, 5'd8, 5'd9), 1'b0,
         alu_ctrl(ALU_ADD, B_RS2, 1'b0), '0);
    push(enc_r(F7_BASE, 3'b000, OPC_OP, 5'd0, 5'd0, 5'd5), 1'b0,
         alu_ctrl(ALU_ADD, B_RS2, 1'b0), '0);

    add_i(64'h5a3, 3'b000, OPC_OP_IMM, alu_ctrl(ALU_ADD, B_IMM, 1'b0));
    add_i(64'hffff_ffff_ffff_f80d, 3'b100, OPC_OP_IMM, alu_ctrl(ALU_XOR, B_IMM, 1'b0));
    add_i(64'h7ff, 3'b010, OPC_OP_IMM, alu_ctrl(ALU_SLT, B_IMM, 1'b0));
    add_i(64'hffff_ffff_ffff_ffff, 3'b011, OPC_OP_IMM, alu_ctrl(ALU_SLTU, B_IMM, 1'b0));
    add_i(64'h0f0, 3'b110, OPC_OP_IMM, alu_ctrl(ALU_OR, B_IMM, 1'b0));
    add_i(64'hffff_ffff_ffff_fe00, 3'b111, OPC_OP_IMM, alu_ctrl(ALU_AND, B_IMM, 1'b0));
    add_i(64'h02d, 3'b001, OPC_OP_IMM, alu_ctrl(ALU_SLL, B_IMM, 1'b0));
    add_i(64'h03f, 3'b101, OPC_OP_IMM, alu_ctrl(ALU_SRL, B_IMM, 1'b0));
    add_i(64'h421, 3'b101, OPC_OP_IMM, alu_ctrl(ALU_SRA, B_IMM, 1'b0)); // shamt 33
    add_i(64'hffff_ffff_ffff_f801, 3'b000, OPC_OP_IMM_32, alu_ctrl(ALU_ADD, B_IMM, 1'b1));
    add_i(64'h01f, 3'b001, OPC_OP_IMM_32, alu_ctrl(ALU_SLL, B_IMM, 1'b1));
    add_i(64'h00c, 3'b101, OPC_OP_IMM_32, alu_ctrl(ALU_SRL, B_IMM, 1'b1));
    add_i(64'h40a, 3'b101, OPC_OP_IMM_32, alu_ctrl(ALU_SRA, B_IMM, 1'b1));

    add_r(F7_BASE, 3'b000, OPC_OP, ALU_ADD, 1'b0);
    add_r(F7_ALT, 3'b000, OPC_OP, ALU_SUB, 1'b0);
    add_r(F7_BASE, 3'b001, OPC_OP, ALU_SLL, 1'b0);
    add_r(F7_BASE, 3'b010, OPC_OP, ALU_SLT, 1'b0);
    add_r(F7_BASE, 3'b011, OPC_OP, ALU_SLTU, 1'b0);
    add_r(F7_BASE, 3'b100, OPC_OP, ALU_XOR, 1'b0);
    add_r(F7_BASE, 3'b101, OPC_OP, ALU_SRL, 1'b0);
    add_r(F7_ALT, 3'b101, OPC_OP, ALU_SRA, 1'b0);
    add_r(F7_BASE, 3'b110, OPC_OP, ALU_OR, 1'b0);
    add_r(F7_BASE, 3'b111, OPC_OP, ALU_AND, 1'b0);
    add_r(F7_BASE, 3'b000, OPC_OP_32, ALU_ADD, 1'b1);
    add_r(F7_ALT, 3'b000, OPC_OP_32, ALU_SUB, 1'b1);
    add_r(F7_BASE, 3'b001, OPC_OP_32, ALU_SLL, 1'b1);
    add_r(F7_BASE, 3'b101, OPC_OP_32, ALU_SRL, 1'b1);
    add_r(F7_ALT, 3'b101, OPC_OP_32, ALU_SRA, 1'b1);

    add_u(64'h0000_0000_7abc_d000, OPC_LUI, alu_ctrl(ALU_COPY_IMM, B_IMM, 1'b0));
    add_u(64'hffff_ffff_8abc_d000, OPC_LUI, alu_ctrl(ALU_COPY_IMM, B_IMM, 1'b0));
    add_u(64'h0000_0000_0001_f000, OPC_AUIPC, pc_ctrl(B_IMM, BR_NONE));
    add_u(64'hffff_ffff_8abc_d000, OPC_AUIPC, pc_ctrl(B_IMM, BR_NONE));
    add_j(64'h0000_0000_0007_5f2e);
    add_j(64'hffff_ffff_fff8_a0d4);
    add_i(64'h124, 3'b000, OPC_JALR, pc_ctrl(B_FOUR, BR_JALR));
    add_i(64'hffff_ffff_ffff_fff0, 3'b000, OPC_JALR, pc_ctrl(B_FOUR, BR_JALR));

    add_i(64'h010, 3'b000, OPC_LOAD, load_ctrl(MEM_B));
    add_i(64'h022, 3'b001, OPC_LOAD, load_ctrl(MEM_H));
    add_i(64'hffff_ffff_ffff_ff04, 3'b010, OPC_LOAD, load_ctrl(MEM_W));
    add_i(64'h3f8, 3'b011, OPC_LOAD, load_ctrl(MEM_D));
    add_i(64'h001, 3'b100, OPC_LOAD, load_ctrl(MEM_BU));
    add_i(64'h00e, 3'b101, OPC_LOAD, load_ctrl(MEM_HU));
    add_i(64'h6a0, 3'b110, OPC_LOAD, load_ctrl(MEM_WU));
    add_s(64'h345, 3'b011, MEM_D);
    add_s(64'hffff_ffff_ffff_f9a7, 3'b000, MEM_B);
    add_s(64'h7f8, 3'b001, MEM_H);
    add_s(64'hffff_ffff_ffff_fffc, 3'b010, MEM_W);

    add_b(64'habc, 3'b000, BR_EQ, ALU_SLT);
    add_b(64'hffff_ffff_ffff_f3d6, 3'b001, BR_NE, ALU_SLT);
    add_b(64'h010, 3'b100, BR_LT, ALU_SLT);
    add_b(64'hffff_ffff_ffff_fffe, 3'b101, BR_GE, ALU_SLT);
    add_b(64'h7fe, 3'b110, BR_LT, ALU_SLTU);
    add_b(64'h0ffe, 3'b111, BR_GE, ALU_SLTU);

    // mul, csrrw, ecall, unknown opcode, then the zero word
    push(enc_r(7'b0000001, 3'b000, OPC_OP, 5'd1, 5'd2, 5'd3), 1'b1, invalid_ctrl(1'b1), '0);
    push(enc_i(64'h300, 3'b001, 7'b1110011, 5'd1, 5'd2), 1'b1, invalid_ctrl(1'b1), '0);
    push(32'h0000_0073, 1'b1, invalid_ctrl(1'b1), '0);
    push(32'h1234_567f, 1'b1, invalid_ctrl(1'b1), '0);
    push(32'h0000_0000, 1'b1, invalid_ctrl(1'b0), '0);
    push(enc_r(F7_BASE, 3'b000, OPC_OP, 5'd0, 5'd1, 5'd1), 1'b0,
         alu_ctrl(ALU_ADD, B_RS2, 1'b0), '0);
  endtask

  task automatic report_failure();
    $display("*** FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(string name, int idx, logic [63:0] exp, logic [63:0] act);
    assert (act === exp) else begin
      $display("ERROR %s entry %0d expected 0x%h actual 0x%h", name, idx, exp, act);
      report_failure();
    end
  endtask

  initial begin
    int waited;
    i_inst     = '0;
    i_wb_data  = '0;
    i_wb_valid = 1'b0;
    lcg_state  = 64'd2638;
    for (int r = 0; r < NUM_REGS; r++) begin
      model[r] = '0;
    end
    build_table();

    waited = 0;
    while (i_rst_n !== 1'b1) begin
      @(posedge i_clk);
      waited++;
      if (waited > 20) begin
        $display("reset was not released within 20 cycles");
        report_failure();
      end
    end
    @(posedge i_clk);
    #2;

    for (int k = 0; k < table_q.size(); k++) begin
      i_inst     = table_q[k].inst;
      i_wb_data  = table_q[k].wb_data;
      i_wb_valid = table_q[k].wb_valid;
      #36; // just before the next edge
      check_word("o_ctrl", k, table_q[k].ctrl, o_ctrl);
      check_word("o_imm", k, table_q[k].imm, o_imm);
      check_word("o_rs1_data", k, table_q[k].rs1, o_rs1_data);
      check_word("o_rs2_data", k, table_q[k].rs2, o_rs2_data);
      @(posedge i_clk);
      #2;
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: tb.f
verilog/rv_decode_pkg.sv
verilog/inst_classify.sv
verilog/imm_gen.sv
verilog/ctrl_gen.sv
verilog/gpr_file.sv
verilog/idu_top.sv
verification/idu_tb.sv

// File: Bender.yml
package:
  name: idu_decode

sources:
  - verilog/rv_decode_pkg.sv
  - verilog/inst_classify.sv
  - verilog/imm_gen.sv
  - verilog/ctrl_gen.sv
  - verilog/gpr_file.sv
  - verilog/idu_top.sv
  - target: test
    files:
      - verification/idu_tb.sv
